// File: bchDecoderControl_trace.txt
// tag_opcode_target_source_addressOrData_lengthOrFlag, all hex
// tag 1 src cmd, 2 src word (flag last), 3 exp cmd, 4 exp word, 5 exp decodeNeeded, f end
1_01_02_01_00001000_0002
1_2a_02_03_00002000_0004
1_2a_05_01_00003000_0001
1_2a_02_04_00004000_0003
2_00_00_00_aaaa0001_0000
2_00_00_00_aaaa0002_0001
2_00_00_00_11111111_0000
2_00_00_00_22222222_0000
2_00_00_00_44444444_0000
2_00_00_00_77777777_0001
2_00_00_00_bbbb0001_0001
2_00_00_00_0000000f_0000
2_00_00_00_000000f0_0000
2_00_00_00_000000fe_0001
3_01_02_01_00001000_0002
3_2a_02_03_00002000_0003
3_2a_05_01_00003000_0001
3_2a_02_04_00004000_0002
4_00_00_00_aaaa0001_0000
4_00_00_00_aaaa0002_0001
4_00_00_00_11111111_0000
4_00_00_00_22222222_0000
4_00_00_00_44444444_0001
4_00_00_00_bbbb0001_0001
4_00_00_00_0000000f_0000
4_00_00_00_000000f0_0001
5_00_00_00_00000000_0000
5_00_00_00_00000000_0001
f_00_00_00_00000000_0000

// File: bchDecoderControl.f
+incdir+.
bchCmdPkg.sv
bchDataPkg.sv
syncFifo.sv
bchCommandReception.sv
bchInputControl.sv
bchChunkChecker.sv
bchOutputControl.sv
bchDecoderControl.sv
tbBchDecoderControl.sv

// File: tbBchDecoderControl.sv
`timescale 1ns/1ps
`default_nettype none

module tbBchDecoderControl
    import bchCmdPkg::*;
    import bchDataPkg::*;
();

    localparam int traceDepth  = 64;
    localparam int resetCycles = 16;

    // Tag, opcode, target, source, address or data, length or flag
    typedef logic [75:0] recordT;

    logic       iClock;
    logic       reset;
    opcodeT     srcOpcode;
    idT         srcTargetId;
    idT         srcSourceId;
    addressT    srcAddress;
    lengthT     srcLength;
    logic       srcCmdValid;
    logic       srcCmdReady;
    dataWordT   srcWriteData;
    logic       srcWriteValid;
    logic       srcWriteLast;
    logic       srcWriteReady;
    opcodeT     dstOpcode;
    idT         dstTargetId;
    idT         dstSourceId;
    addressT    dstAddress;
    lengthT     dstLength;
    logic       dstCmdValid;
    logic       dstCmdReady;
    dataWordT   dstWriteData;
    logic       dstWriteValid;
    logic       dstWriteLast;
    logic       dstWriteReady;
    logic       errorDetectionEnd;
    logic       decodeNeeded;

    recordT     trace [traceDepth];
    queuedCmdT  srcCmds [$];
    queuedDataT srcWords [$];
    queuedCmdT  expCmds [$];
    queuedDataT expWords [$];
    logic       expChecks [$];
    queuedDataT seenWord;
    integer     seed;
    logic [31:0] rnd;
    int         totalExpected;
    int         checksDone;
    int         watchCycles;

    bchDecoderControl bchDecoderControl_i (
        .iClock, .reset,
        .srcOpcode, .srcTargetId, .srcSourceId, .srcAddress, .srcLength,
        .srcCmdValid, .srcCmdReady,
        .srcWriteData, .srcWriteValid, .srcWriteLast, .srcWriteReady,
        .dstOpcode, .dstTargetId, .dstSourceId, .dstAddress, .dstLength,
        .dstCmdValid, .dstCmdReady,
        .dstWriteData, .dstWriteValid, .dstWriteLast, .dstWriteReady,
        .errorDetectionEnd, .decodeNeeded
    );

    always #5 iClock = ~iClock;

    assign seenWord = {dstWriteData, dstWriteLast};

    task automatic abortRun();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic loadTrace();
        recordT     rec;
        queuedCmdT  cmdRec;
        queuedDataT wordRec;
        int         idx;
        logic       atEnd;
        logic       badTag;
        $readmemh("bchDecoderControl_trace.txt", trace);
        idx    = 0;
        atEnd  = 1'b0;
        badTag = 1'b0;
        while (!atEnd && !badTag && idx < traceDepth) begin
            rec              = trace[idx];
            cmdRec.cmdType   = CmdBypass; // Not visible on the output bus
            cmdRec.opcode    = rec[69:64];
            cmdRec.targetId  = rec[60:56];
            cmdRec.sourceId  = rec[52:48];
            cmdRec.address   = rec[47:16];
            cmdRec.length    = rec[15:0];
            wordRec.data     = rec[47:16];
            wordRec.last     = rec[0];
            case (rec[75:72])
                4'h1:    srcCmds.push_back(cmdRec);
                4'h2:    srcWords.push_back(wordRec);
                4'h3:    expCmds.push_back(cmdRec);
                4'h4:    expWords.push_back(wordRec);
                4'h5:    expChecks.push_back(rec[0]);
                4'hf:    atEnd = 1'b1;
                default: badTag = 1'b1;
            endcase
            idx++;
        end
        if (!atEnd) begin
            $display("Trace file is missing, has a bad record or has no end record");
            abortRun();
        end
    endtask

    task automatic compareCmd(input opcodeT opcode, input idT targetId, input idT sourceId,
                              input addressT address, input lengthT length);
        queuedCmdT expected;
        if (expCmds.size() == 0) begin
            $display("An output command appeared that the trace does not expect");
            abortRun();
        end else begin
            expected = expCmds.pop_front();
            if (expected.opcode !== opcode || expected.targetId !== targetId ||
                expected.sourceId !== sourceId || expected.address !== address ||
                expected.length !== length) begin
                $display("** Error @ %0t: command expected %h %h %h %h %h, got %h %h %h %h %h",
                         $time, expected.opcode, expected.targetId, expected.sourceId,
                         expected.address, expected.length,
                         opcode, targetId, sourceId, address, length);
                abortRun();
            end else begin
                checksDone++;
            end
        end
    endtask

    task automatic compareWord(input queuedDataT actual);
        queuedDataT expected;
        if (expWords.size() == 0) begin
            $display("An output data word appeared that the trace does not expect");
            abortRun();
        end else begin
            expected = expWords.pop_front();
            if (expected !== actual) begin
                $display("** Error @ %0t: word expected %h last %b, got %h last %b",
                         $time, expected.data, expected.last, actual.data, actual.last);
                abortRun();
            end else begin
                checksDone++;
            end
        end
    endtask

    task automatic compareCheck(input logic actualNeeded);
        logic expected;
        if (expChecks.size() == 0) begin
            $display("A detection end pulse appeared that the trace does not expect");
            abortRun();
        end else begin
            expected = expChecks.pop_front();
            if (expected !== actualNeeded) begin
                $display("** Error @ %0t: decodeNeeded expected %b, got %b",
                         $time, expected, actualNeeded);
                abortRun();
            end else begin
                checksDone++;
            end
        end
    endtask

    task automatic sendCmds();
        queuedCmdT nextCmd;
        while (srcCmds.size() > 0) begin
            nextCmd = srcCmds.pop_front();
            @(negedge iClock);
            srcOpcode   = nextCmd.opcode;
            srcTargetId = nextCmd.targetId;
            srcSourceId = nextCmd.sourceId;
            srcAddress  = nextCmd.address;
            srcLength   = nextCmd.length;
            srcCmdValid = 1'b1;
            @(posedge iClock);
            while (!srcCmdReady) @(posedge iClock);
        end
        @(negedge iClock);
        srcCmdValid = 1'b0;
    endtask

    task automatic sendWords();
        queuedDataT nextWord;
        while (srcWords.size() > 0) begin
            nextWord = srcWords.pop_front();
            @(negedge iClock);
            srcWriteData  = nextWord.data;
            srcWriteLast  = nextWord.last;
            srcWriteValid = 1'b1;
            @(posedge iClock);
            while (!srcWriteReady) @(posedge iClock);
        end
        @(negedge iClock);
        srcWriteValid = 1'b0;
    endtask

    // Random back-pressure on both output buses
    always @(negedge iClock) begin
        rnd           = $random(seed);
        dstCmdReady   = rnd[0] | rnd[1];
        dstWriteReady = rnd[2];
    end

    always @(posedge iClock) begin
        if (!reset) begin
            if (dstCmdValid && dstCmdReady) begin
                compareCmd(dstOpcode, dstTargetId, dstSourceId, dstAddress, dstLength);
            end
            if (dstWriteValid && dstWriteReady) compareWord(seenWord);
            if (errorDetectionEnd) compareCheck(decodeNeeded);
        end
    end

    initial begin
        wait (watchCycles > 0);
        repeat (resetCycles + watchCycles) @(posedge iClock);
        $display("Watchdog expired after %0d cycles with %0d of %0d expected items seen",
                 resetCycles + watchCycles, checksDone, totalExpected);
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        iClock        = 1'b0;
        reset         = 1'b1;
        srcOpcode     = '0;
        srcTargetId   = '0;
        srcSourceId   = '0;
        srcAddress    = '0;
        srcLength     = '0;
        srcCmdValid   = 1'b0;
        srcWriteData  = '0;
        srcWriteValid = 1'b0;
        srcWriteLast  = 1'b0;
        dstCmdReady   = 1'b0;
        dstWriteReady = 1'b0;
        seed          = 32'hbaf85d8f;
        checksDone    = 0;
        loadTrace();
        totalExpected = expCmds.size() + expWords.size() + expChecks.size();
        watchCycles   = (srcWords.size() + 1) * 40; // 40 cycles per word
        repeat (resetCycles) @(posedge iClock);
        @(negedge iClock);
        reset = 1'b0;
        fork
            sendCmds();
            sendWords();
        join
        wait (checksDone == totalExpected);
        repeat (20) @(posedge iClock); // Catch late extra outputs
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: bchDecoderControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "bchDecCfg.svh"

module bchDecoderControl
    import bchCmdPkg::*;
    import bchDataPkg::*;
(
    input  wire logic     iClock,
    input  wire logic     reset,
    input  wire opcodeT   srcOpcode,
    input  wire idT       srcTargetId,
    input  wire idT       srcSourceId,
    input  wire addressT  srcAddress,
    input  wire lengthT   srcLength,
    input  wire logic     srcCmdValid,
    output logic          srcCmdReady,
    input  wire dataWordT srcWriteData,
    input  wire logic     srcWriteValid,
    input  wire logic     srcWriteLast,
    output logic          srcWriteReady,
    output opcodeT        dstOpcode,
    output idT            dstTargetId,
    output idT            dstSourceId,
    output addressT       dstAddress,
    output lengthT        dstLength,
    output logic          dstCmdValid,
    input  wire logic     dstCmdReady,
    output dataWordT      dstWriteData,
    output logic          dstWriteValid,
    output logic          dstWriteLast,
    input  wire logic     dstWriteReady,
    output logic          errorDetectionEnd,
    output logic          decodeNeeded
);

    queuedCmdT  queuedCmd;
    logic       queuedCmdValid;
    logic       queuedCmdReady;
    queuedCmdT  cmd;
    logic       cmdValid;
    logic       cmdReady;
    dataWordT   bypassData;
    logic       bypassLast;
    logic       bypassValid;
    logic       bypassReady;
    dataWordT   decData;
    logic       decValid;
    logic       decReady;
    logic       decInLast;
    dataWordT   checkedData;
    logic       checkedLast;
    logic       checkedValid;
    logic       checkedReady;
    queuedDataT bufferedData;
    logic       bufferedValid;
    logic       bufferedReady;
    logic       queueFull;
    logic       queueEmpty;
    logic       queuePop;
    queuedDataT queueHead;
    queuedDataT outWord;

    bchCommandReception cmdReception (
        .iClock, .reset,
        .srcOpcode, .srcTargetId, .srcSourceId, .srcAddress, .srcLength,
        .srcCmdValid, .srcCmdReady,
        .queuedCmd, .queuedCmdValid, .queuedCmdReady
    );

    bchInputControl inputControl (
        .iClock, .reset,
        .queuedCmd, .queuedCmdValid, .queuedCmdReady,
        .cmd, .cmdValid, .cmdReady,
        .srcWriteData, .srcWriteValid, .srcWriteLast, .srcWriteReady,
        .bypassData, .bypassLast, .bypassValid, .bypassReady,
        .decData, .decValid, .decReady, .decInLast
    );

    bchChunkChecker chunkChecker (
        .iClock, .reset,
        .decData, .decValid,
        .srcLast (srcWriteLast), // Marks the check word
        .decReady, .decInLast,
        .checkedData, .checkedLast, .checkedValid, .checkedReady,
        .errorDetectionEnd, .decodeNeeded
    );

    bchOutputControl outputControl (
        .iClock, .reset,
        .cmd, .cmdValid, .cmdReady,
        .dstOpcode, .dstTargetId, .dstSourceId, .dstAddress, .dstLength,
        .dstCmdValid, .dstCmdReady,
        .bypassData, .bypassLast, .bypassValid, .bypassReady,
        .checkedData, .checkedLast, .checkedValid, .checkedReady,
        .bufferedData, .bufferedValid, .bufferedReady
    );

    assign bufferedReady = !queueFull;

    syncFifo #(
        .payloadT (queuedDataT),
        .DEPTH    (`DATA_QUEUE_DEPTH)
    ) dataQueue (
        .iClock   (iClock),
        .reset    (reset),
        .pushData (bufferedData),
        .push     (bufferedValid),
        .full     (queueFull),
        .popData  (queueHead),
        .pop      (queuePop),
        .empty    (queueEmpty)
    );

    // Refill the output word when empty or taken
    assign queuePop = !queueEmpty && (!dstWriteValid || dstWriteReady);

    always_ff @(posedge iClock) begin
        if (queuePop) outWord <= queueHead;
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            dstWriteValid <= 1'b0;
        end else if (queuePop) begin
            dstWriteValid <= 1'b1;
        end else if (dstWriteReady) begin
            dstWriteValid <= 1'b0;
        end
    end

    assign dstWriteData = outWord.data;
    assign dstWriteLast = outWord.last;

endmodule

`default_nettype wire

// File: bchOutputControl.sv
`timescale 1ns/1ps
`default_nettype none

module bchOutputControl
    import bchCmdPkg::*;
    import bchDataPkg::*;
(
    input  wire logic      iClock,
    input  wire logic      reset,
    input  wire queuedCmdT cmd,
    input  wire logic      cmdValid,
    output logic           cmdReady,
    output opcodeT         dstOpcode,
    output idT             dstTargetId,
    output idT             dstSourceId,
    output addressT        dstAddress,
    output lengthT         dstLength,
    output logic           dstCmdValid,
    input  wire logic      dstCmdReady,
    input  wire dataWordT  bypassData,
    input  wire logic      bypassLast,
    input  wire logic      bypassValid,
    output logic           bypassReady,
    input  wire dataWordT  checkedData,
    input  wire logic      checkedLast,
    input  wire logic      checkedValid,
    output logic           checkedReady,
    output queuedDataT     bufferedData,
    output logic           bufferedValid,
    input  wire logic      bufferedReady
);

    typedef enum logic [1:0] {
        StIdle,
        StCmd,
        StData
    } stateT;

    stateT     state;
    queuedCmdT cmdReg;
    logic      fromDecoder;
    logic      inData;

    assign fromDecoder = cmdReg.cmdType == CmdDecode;
    assign inData      = state == StData;

    assign cmdReady    = state == StIdle;
    assign dstOpcode   = cmdReg.opcode;
    assign dstTargetId = cmdReg.targetId;
    assign dstSourceId = cmdReg.sourceId;
    assign dstAddress  = cmdReg.address;
    assign dstLength   = cmdReg.length;
    assign dstCmdValid = state == StCmd;

    // Data mux by command type
    assign bufferedData.data = fromDecoder ? checkedData : bypassData;
    assign bufferedData.last = fromDecoder ? checkedLast : bypassLast;
    assign bufferedValid     = inData && (fromDecoder ? checkedValid : bypassValid);
    assign bypassReady       = inData && !fromDecoder && bufferedReady;
    assign checkedReady      = inData && fromDecoder && bufferedReady;

    always_ff @(posedge iClock) begin
        if (cmdValid && cmdReady) begin
            cmdReg <= cmd;
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            state <= StIdle;
        end else begin
            case (state)
                StIdle: if (cmdValid) state <= StCmd;
                StCmd:  if (dstCmdReady) state <= StData;
                StData: begin
                    if (bufferedValid && bufferedReady && bufferedData.last) begin
                        state <= StIdle;
                    end
                end
                default: state <= StIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: bchChunkChecker.sv
`timescale 1ns/1ps
`default_nettype none

module bchChunkChecker
    import bchDataPkg::*;
(
    input  wire logic     iClock,
    input  wire logic     reset,
    input  wire dataWordT decData,
    input  wire logic     decValid,
    input  wire logic     srcLast,
    output logic          decReady,
    output logic          decInLast,
    output dataWordT      checkedData,
    output logic          checkedLast,
    output logic          checkedValid,
    input  wire logic     checkedReady,
    output logic          errorDetectionEnd,
    output logic          decodeNeeded
);

    dataWordT holdData;
    logic     holdValid;
    dataWordT syndrome;
    logic     outFree;
    logic     acceptIn;

    assign outFree   = !checkedValid || checkedReady;
    assign decReady  = !holdValid || outFree;
    assign acceptIn  = decValid && decReady;
    assign decInLast = decValid && srcLast; // Incoming word is the check word

    always_ff @(posedge iClock) begin
        if (acceptIn) begin
            if (holdValid) checkedData <= holdData;
            if (!srcLast) holdData <= decData;
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            holdValid         <= 1'b0;
            checkedValid      <= 1'b0;
            checkedLast       <= 1'b0;
            syndrome          <= '0;
            errorDetectionEnd <= 1'b0;
            decodeNeeded      <= 1'b0;
        end else begin
            errorDetectionEnd <= 1'b0;
            if (checkedValid && checkedReady) checkedValid <= 1'b0;
            if (acceptIn) begin
                if (holdValid) begin
                    checkedValid <= 1'b1;
                    checkedLast  <= srcLast; // Last payload word goes out with the check
                end
                if (srcLast) begin
                    holdValid         <= 1'b0;
                    syndrome          <= '0;
                    errorDetectionEnd <= 1'b1;
                    decodeNeeded      <= syndrome != decData;
                end else begin
                    holdValid <= 1'b1;
                    syndrome  <= syndrome ^ decData;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bchInputControl.sv
`timescale 1ns/1ps
`default_nettype none

module bchInputControl
    import bchCmdPkg::*;
    import bchDataPkg::*;
(
    input  wire logic      iClock,
    input  wire logic      reset,
    input  wire queuedCmdT queuedCmd,
    input  wire logic      queuedCmdValid,
    output logic           queuedCmdReady,
    output queuedCmdT      cmd,
    output logic           cmdValid,
    input  wire logic      cmdReady,
    input  wire dataWordT  srcWriteData,
    input  wire logic      srcWriteValid,
    input  wire logic      srcWriteLast,
    output logic           srcWriteReady,
    output dataWordT       bypassData,
    output logic           bypassLast,
    output logic           bypassValid,
    input  wire logic      bypassReady,
    output dataWordT       decData,
    output logic           decValid,
    input  wire logic      decReady,
    input  wire logic      decInLast
);

    typedef enum logic [1:0] {
        StIdle,
        StIssue,
        StData
    } stateT;

    stateT     state;
    queuedCmdT cmdReg;
    logic      toDecoder;
    logic      wordTaken;
    logic      pathLast;

    assign toDecoder = cmdReg.cmdType == CmdDecode;

    assign queuedCmdReady = state == StIdle;
    assign cmd            = cmdReg;
    assign cmdValid       = state == StIssue;

    // Steer source words to the selected path only
    assign bypassData  = srcWriteData;
    assign bypassLast  = srcWriteLast;
    assign bypassValid = (state == StData) && !toDecoder && srcWriteValid;
    assign decData     = srcWriteData;
    assign decValid    = (state == StData) && toDecoder && srcWriteValid;

    assign srcWriteReady = (state == StData) && (toDecoder ? decReady : bypassReady);
    assign wordTaken     = srcWriteValid && srcWriteReady;
    assign pathLast      = toDecoder ? decInLast : srcWriteLast;

    always_ff @(posedge iClock) begin
        if (queuedCmdValid && queuedCmdReady) begin
            cmdReg <= queuedCmd;
            if (queuedCmd.cmdType == CmdDecode) begin
                cmdReg.length <= queuedCmd.length - lengthT'(1); // Check word is stripped
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            state <= StIdle;
        end else begin
            case (state)
                StIdle:  if (queuedCmdValid) state <= StIssue;
                StIssue: if (cmdReady) state <= StData;
                StData:  if (wordTaken && pathLast) state <= StIdle;
                default: state <= StIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: bchCommandReception.sv
`timescale 1ns/1ps
`default_nettype none

`include "bchDecCfg.svh"

module bchCommandReception
    import bchCmdPkg::*;
(
    input  wire logic    iClock,
    input  wire logic    reset,
    input  wire opcodeT  srcOpcode,
    input  wire idT      srcTargetId,
    input  wire idT      srcSourceId,
    input  wire addressT srcAddress,
    input  wire lengthT  srcLength,
    input  wire logic    srcCmdValid,
    output logic         srcCmdReady,
    output queuedCmdT    queuedCmd,
    output logic         queuedCmdValid,
    input  wire logic    queuedCmdReady
);

    queuedCmdT pushCmd;
    logic      queueFull;
    logic      queueEmpty;
    logic      isDecode;

    assign isDecode = (srcTargetId == idT'(`THIS_ID)) && (srcOpcode == `DECODE_OPCODE);

    always_comb begin
        pushCmd.cmdType  = isDecode ? CmdDecode : CmdBypass;
        pushCmd.opcode   = srcOpcode;
        pushCmd.targetId = srcTargetId;
        pushCmd.sourceId = srcSourceId;
        pushCmd.address  = srcAddress;
        pushCmd.length   = srcLength;
    end

    assign srcCmdReady    = !queueFull;
    assign queuedCmdValid = !queueEmpty;

    syncFifo #(
        .payloadT (queuedCmdT),
        .DEPTH    (`CMD_QUEUE_DEPTH)
    ) cmdQueue (
        .iClock   (iClock),
        .reset    (reset),
        .pushData (pushCmd),
        .push     (srcCmdValid), // Ignored while full
        .full     (queueFull),
        .popData  (queuedCmd),
        .pop      (queuedCmdReady),
        .empty    (queueEmpty)
    );

endmodule

`default_nettype wire

// File: syncFifo.sv
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  DEPTH    = 4
) (
    input  wire logic    iClock,
    input  wire logic    reset,
    input  wire payloadT pushData,
    input  wire logic    push,
    output logic         full,
    output payloadT      popData,
    input  wire logic    pop,
    output logic         empty
);

    localparam int ptrWidth = $clog2(DEPTH) + 1; // Extra wrap bit

    payloadT               mem [DEPTH];
    logic [ptrWidth - 1:0] wrPtr;
    logic [ptrWidth - 1:0] rdPtr;
    logic                  doPush;
    logic                  doPop;

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign empty   = wrPtr == rdPtr;
    assign full    = (wrPtr - rdPtr) == ptrWidth'(DEPTH);
    assign popData = mem[rdPtr % DEPTH]; // Head word is always visible

    always_ff @(posedge iClock) begin
        if (doPush) begin
            mem[wrPtr % DEPTH] <= pushData;
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bchDataPkg.sv
`default_nettype none

`include "bchDecCfg.svh"

package bchDataPkg;

    typedef logic [`DATA_WIDTH - 1:0] dataWordT;

    // Word plus last flag, as stored in the output data queue
    typedef struct packed {
        dataWordT data;
        logic     last;
    } queuedDataT;

endpackage

`default_nettype wire

// File: bchCmdPkg.sv
`default_nettype none

`include "bchDecCfg.svh"

package bchCmdPkg;

    typedef logic [5:0]                  opcodeT;
    typedef logic [4:0]                  idT;
    typedef logic [`ADDRESS_WIDTH - 1:0] addressT;
    typedef logic [`LENGTH_WIDTH - 1:0]  lengthT;

    typedef enum logic [1:0] {
        CmdBypass = 2'd0,
        CmdDecode = 2'd1
    } cmdTypeT;

    // Command as it sits in the queue and travels between blocks
    typedef struct packed {
        cmdTypeT cmdType;
        opcodeT  opcode;
        idT      targetId;
        idT      sourceId;
        addressT address;
        lengthT  length;
    } queuedCmdT;

endpackage

`default_nettype wire

// File: bchDecCfg.svh
`ifndef BCH_DEC_CFG_SVH
`define BCH_DEC_CFG_SVH

// Bus widths
`define ADDRESS_WIDTH     32
`define DATA_WIDTH        32
`define LENGTH_WIDTH      16

// Stage identity and the opcode it decodes
`define THIS_ID           2
`define DECODE_OPCODE     6'h2a

// Queue depths, powers of two
`define CMD_QUEUE_DEPTH   4
`define DATA_QUEUE_DEPTH  16

`endif
